/* hw/saturn_bus_pkg.sv */
package saturn_bus_pkg;

  typedef logic [3:0]  nibble_t;
  typedef logic [19:0] addr_t;

  // a LOAD command is followed by this many address nibbles, low nibble first
  localparam int ADDR_NIBBLES = 5;

  // memory decodes only the low address bits, higher addresses alias
  localparam int MEM_ADDR_BITS = 8;

  // Saturn bus command set, only the commands used here
  typedef enum logic [3:0] {
    NOP      = 4'h0,
    PC_READ  = 4'h2,
    DP_READ  = 4'h3,
    DP_WRITE = 4'h5,
    LOAD_PC  = 4'h6,
    LOAD_DP  = 4'h7
  } bus_cmd_e;

  typedef enum logic {
    REQ_READ  = 1'b0,
    REQ_WRITE = 1'b1
  } req_kind_e;

endpackage

/* hw/saturn_fetch_port.sv */
`timescale 1ns/100ps

module saturn_fetch_port (
  input  logic                    i_clk,
  input  logic                    do_cmd_reset,
  input  logic                    i_psel,
  input  logic                    i_penable,
  input  saturn_bus_pkg::addr_t   i_paddr,
  input  logic                    i_gnt,
  input  logic                    i_done,
  input  saturn_bus_pkg::nibble_t i_rdata,
  input  logic                    i_fetch_flush,
  output logic                    o_pready,
  output saturn_bus_pkg::nibble_t o_prdata,
  output logic                    o_req,
  output logic                    o_req_load,
  output saturn_bus_pkg::addr_t   o_req_addr
);
  import saturn_bus_pkg::*;

  // next address the memory PC will serve
  addr_t   pc;
  logic    pc_valid;
  // one nibble prefetch buffer
  logic    buf_valid;
  addr_t   buf_addr;
  nibble_t buf_data;
  logic    req_demand;
  logic    resp_ready;
  nibble_t resp_data;
  logic    hit;
  logic    xfer_done;

  assign hit = i_psel && i_penable && buf_valid && !i_fetch_flush && (buf_addr == i_paddr);
  assign xfer_done = o_req && i_gnt && i_done;
  assign o_pready = hit || resp_ready;
  assign o_prdata = hit ? buf_data : resp_data;

  always_ff @(posedge i_clk) begin
    if (do_cmd_reset) begin
      pc_valid   <= 1'b0;
      buf_valid  <= 1'b0;
      req_demand <= 1'b0;
      resp_ready <= 1'b0;
      o_req      <= 1'b0;
    end else begin
      resp_ready <= 1'b0;
      if (xfer_done) begin
        o_req    <= 1'b0;
        pc       <= o_req_addr + 20'd1;
        pc_valid <= 1'b1;
        if (req_demand) begin
          resp_ready <= 1'b1;
          resp_data  <= i_rdata;
        end else begin
          buf_valid <= 1'b1;
          buf_addr  <= o_req_addr;
          buf_data  <= i_rdata;
        end
      end else if (i_psel && i_penable && !hit && !o_req && !resp_ready) begin
        // miss, fetch the nibble on demand and drop the stale buffer
        o_req      <= 1'b1;
        req_demand <= 1'b1;
        o_req_addr <= i_paddr;
        o_req_load <= !(pc_valid && (pc == i_paddr));
        buf_valid  <= 1'b0;
      end else if (!i_psel && !o_req && !buf_valid && pc_valid) begin
        // idle, read ahead at the tracked PC
        o_req      <= 1'b1;
        req_demand <= 1'b0;
        o_req_addr <= pc;
        o_req_load <= 1'b0;
      end
      // buffer consumed by a hit, or stale after a data write
      if (hit || i_fetch_flush) begin
        buf_valid <= 1'b0;
      end
    end
  end

  assert property (@(posedge i_clk) disable iff (do_cmd_reset)
    (i_psel && !o_pready) |=> (i_psel && $stable(i_paddr)));

endmodule

/* hw/saturn_data_port.sv */
`timescale 1ns/100ps

module saturn_data_port (
  input  logic                      i_clk,
  input  logic                      do_cmd_reset,
  input  logic                      i_psel,
  input  logic                      i_penable,
  input  logic                      i_pwrite,
  input  saturn_bus_pkg::addr_t     i_paddr,
  input  saturn_bus_pkg::nibble_t   i_pwdata,
  input  logic                      i_gnt,
  input  logic                      i_done,
  input  saturn_bus_pkg::nibble_t   i_rdata,
  output logic                      o_pready,
  output saturn_bus_pkg::nibble_t   o_prdata,
  output logic                      o_req,
  output logic                      o_req_load,
  output saturn_bus_pkg::req_kind_e o_req_kind,
  output saturn_bus_pkg::addr_t     o_req_addr,
  output saturn_bus_pkg::nibble_t   o_req_wdata
);
  import saturn_bus_pkg::*;

  // mirror of the memory DP pointer
  addr_t dp;
  logic  dp_valid;

  always_ff @(posedge i_clk) begin
    if (do_cmd_reset) begin
      dp_valid <= 1'b0;
      o_req    <= 1'b0;
      o_pready <= 1'b0;
    end else begin
      o_pready <= 1'b0;
      if (o_req && i_gnt && i_done) begin
        o_req    <= 1'b0;
        o_pready <= 1'b1;
        o_prdata <= i_rdata;
        dp       <= o_req_addr + 20'd1;
        dp_valid <= 1'b1;
      end else if (i_psel && i_penable && !o_req && !o_pready) begin
        o_req       <= 1'b1;
        o_req_kind  <= i_pwrite ? REQ_WRITE : REQ_READ;
        o_req_addr  <= i_paddr;
        o_req_wdata <= i_pwdata;
        o_req_load  <= !(dp_valid && (dp == i_paddr));
      end
    end
  end

  assert property (@(posedge i_clk) disable iff (do_cmd_reset) i_penable |-> i_psel);

endmodule

/* hw/saturn_bus_arbiter.sv */
`timescale 1ns/100ps

module saturn_bus_arbiter (
  input  logic                      i_clk,
  input  logic                      do_cmd_reset,
  input  logic                      i_fetch_req,
  input  logic                      i_fetch_req_load,
  input  saturn_bus_pkg::addr_t     i_fetch_req_addr,
  input  logic                      i_data_req,
  input  logic                      i_data_req_load,
  input  saturn_bus_pkg::req_kind_e i_data_req_kind,
  input  saturn_bus_pkg::addr_t     i_data_req_addr,
  input  saturn_bus_pkg::nibble_t   i_data_req_wdata,
  input  logic                      i_done,
  output logic                      o_fetch_gnt,
  output logic                      o_data_gnt,
  output logic                      o_req,
  output logic                      o_req_load,
  output saturn_bus_pkg::req_kind_e o_req_kind,
  output saturn_bus_pkg::addr_t     o_req_addr,
  output saturn_bus_pkg::nibble_t   o_req_wdata,
  output logic                      o_sel_data,
  output logic                      o_fetch_flush
);
  import saturn_bus_pkg::*;

  logic busy;
  logic owner_data;
  logic prio_data;
  logic win_data;

  // data port wins when alone or when it holds the priority
  assign win_data = i_data_req && (!i_fetch_req || prio_data);

  always_ff @(posedge i_clk) begin
    if (do_cmd_reset) begin
      busy       <= 1'b0;
      owner_data <= 1'b0;
      prio_data  <= 1'b0;
    end else if (!busy) begin
      if (i_fetch_req || i_data_req) begin
        busy       <= 1'b1;
        owner_data <= win_data;
      end
    end else if (i_done) begin
      busy      <= 1'b0;
      prio_data <= !owner_data;
    end
  end

  assign o_fetch_gnt = busy && !owner_data;
  assign o_data_gnt  = busy && owner_data;
  assign o_sel_data  = owner_data;
  assign o_req       = o_data_gnt ? i_data_req : (o_fetch_gnt && i_fetch_req);
  assign o_req_load  = owner_data ? i_data_req_load : i_fetch_req_load;
  assign o_req_kind  = owner_data ? i_data_req_kind : REQ_READ;
  assign o_req_addr  = owner_data ? i_data_req_addr : i_fetch_req_addr;
  // fetch port never writes
  assign o_req_wdata = i_data_req_wdata;

  // the prefetched nibble may be stale once a write lands
  assign o_fetch_flush = o_data_gnt && i_done && (i_data_req_kind == REQ_WRITE);

  // granted port keeps its request up until done
  assert property (@(posedge i_clk) disable iff (do_cmd_reset) (busy && !i_done) |-> o_req);

endmodule

/* hw/saturn_bus_ctrl.sv */
`timescale 1ns/100ps

module saturn_bus_ctrl (
  input  logic                      i_clk,
  input  logic                      do_cmd_reset,
  input  logic                      i_req,
  input  logic                      i_req_load,
  input  saturn_bus_pkg::req_kind_e i_req_kind,
  input  saturn_bus_pkg::addr_t     i_req_addr,
  input  saturn_bus_pkg::nibble_t   i_req_wdata,
  input  logic                      i_sel_data,
  input  saturn_bus_pkg::nibble_t   i_bus_data,
  output saturn_bus_pkg::nibble_t   o_bus_data,
  output logic                      o_bus_strobe,
  output logic                      o_bus_cmd_data,
  output logic                      o_done,
  output saturn_bus_pkg::nibble_t   o_rdata
);
  import saturn_bus_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_ADDR,
    S_WCMD,
    S_WDATA,
    S_READ,
    S_LAST
  } state_e;

  state_e     state;
  // last command seen by the memory, i.e. its current mode
  bus_cmd_e   mode;
  logic [2:0] addr_cnt;
  logic       is_write;
  bus_cmd_e   read_cmd;
  bus_cmd_e   load_cmd;

  assign is_write = (i_req_kind == REQ_WRITE);
  assign read_cmd = i_sel_data ? DP_READ : PC_READ;
  assign load_cmd = i_sel_data ? LOAD_DP : LOAD_PC;
  // memory answer is registered, so it is on the bus in the done cycle
  assign o_rdata = i_bus_data;

  always_ff @(posedge i_clk) begin
    if (do_cmd_reset) begin
      state          <= S_IDLE;
      mode           <= NOP;
      addr_cnt       <= '0;
      o_bus_strobe   <= 1'b0;
      o_bus_cmd_data <= 1'b1;
      o_done         <= 1'b0;
    end else begin
      // strobe, done and the address/data marking last one cycle
      o_bus_strobe   <= 1'b0;
      o_bus_cmd_data <= 1'b1;
      o_done         <= 1'b0;
      case (state)
        S_IDLE: begin
          // request is still up in the done cycle
          if (i_req && !o_done) begin
            o_bus_strobe <= 1'b1;
            if (i_req_load) begin
              o_bus_data <= load_cmd;
              mode       <= load_cmd;
              addr_cnt   <= '0;
              state      <= S_ADDR;
            end else if (is_write && (mode != DP_WRITE)) begin
              o_bus_data <= DP_WRITE;
              mode       <= DP_WRITE;
              state      <= S_WDATA;
            end else if (is_write) begin
              o_bus_cmd_data <= 1'b0;
              o_bus_data     <= i_req_wdata;
              state          <= S_LAST;
            end else if (mode != read_cmd) begin
              // PC_READ here restores instruction mode after data traffic
              o_bus_data <= read_cmd;
              mode       <= read_cmd;
              state      <= S_READ;
            end else begin
              o_bus_cmd_data <= 1'b0;
              state          <= S_LAST;
            end
          end
        end
        S_ADDR: begin
          o_bus_strobe   <= 1'b1;
          o_bus_cmd_data <= 1'b0;
          o_bus_data     <= i_req_addr[{addr_cnt, 2'b00} +: 4];
          addr_cnt       <= addr_cnt + 3'd1;
          if (addr_cnt == 3'(ADDR_NIBBLES - 1)) begin
            // memory drops into read mode on its own after the address
            mode  <= (mode == LOAD_PC) ? PC_READ : DP_READ;
            state <= is_write ? S_WCMD : S_READ;
          end
        end
        S_WCMD: begin
          o_bus_strobe <= 1'b1;
          o_bus_data   <= DP_WRITE;
          mode         <= DP_WRITE;
          state        <= S_WDATA;
        end
        S_WDATA: begin
          o_bus_strobe   <= 1'b1;
          o_bus_cmd_data <= 1'b0;
          o_bus_data     <= i_req_wdata;
          state          <= S_LAST;
        end
        S_READ: begin
          o_bus_strobe   <= 1'b1;
          o_bus_cmd_data <= 1'b0;
          state          <= S_LAST;
        end
        S_LAST: begin
          o_done <= 1'b1;
          state  <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // strobes only go out for a live request
  assert property (@(posedge i_clk) disable iff (do_cmd_reset) o_bus_strobe |-> i_req);

endmodule

/* hw/saturn_nibble_mem.sv */
`timescale 1ns/100ps

module saturn_nibble_mem (
  input  logic                    i_clk,
  input  logic                    do_cmd_reset,
  input  saturn_bus_pkg::nibble_t i_bus_data,
  input  logic                    i_bus_strobe,
  input  logic                    i_bus_cmd_data,
  output saturn_bus_pkg::nibble_t o_bus_data
);
  import saturn_bus_pkg::*;

  nibble_t    mem [2**MEM_ADDR_BITS];
  bus_cmd_e   mode;
  logic [2:0] addr_cnt;
  addr_t      pc;
  addr_t      dp;

  always_ff @(posedge i_clk) begin
    if (do_cmd_reset) begin
      mode     <= NOP;
      addr_cnt <= '0;
      pc       <= '0;
      dp       <= '0;
      for (int i = 0; i < 2**MEM_ADDR_BITS; i++) begin
        mem[i] <= '0;
      end
    end else if (i_bus_strobe) begin
      if (i_bus_cmd_data) begin
        mode     <= bus_cmd_e'(i_bus_data);
        addr_cnt <= '0;
      end else if ((mode == LOAD_PC) || (mode == LOAD_DP)) begin
        // address arrives low nibble first, shift in from the top
        if (mode == LOAD_PC) begin
          pc <= {i_bus_data, pc[19:4]};
        end else begin
          dp <= {i_bus_data, dp[19:4]};
        end
        addr_cnt <= addr_cnt + 3'd1;
        if (addr_cnt == 3'(ADDR_NIBBLES - 1)) begin
          mode <= (mode == LOAD_PC) ? PC_READ : DP_READ;
        end
      end else begin
        case (mode)
          PC_READ: begin
            o_bus_data <= mem[pc[MEM_ADDR_BITS-1:0]];
            pc         <= pc + 20'd1;
          end
          DP_READ: begin
            o_bus_data <= mem[dp[MEM_ADDR_BITS-1:0]];
            dp         <= dp + 20'd1;
          end
          DP_WRITE: begin
            mem[dp[MEM_ADDR_BITS-1:0]] <= i_bus_data;
            dp                         <= dp + 20'd1;
          end
          default: ;
        endcase
      end
    end
  end

endmodule

/* hw/saturn_bus_top.sv */
`timescale 1ns/100ps

module saturn_bus_top (
  input  logic                    i_clk,
  input  logic                    do_cmd_reset,
  // fetch channel
  input  logic                    i_f_psel,
  input  logic                    i_f_penable,
  input  saturn_bus_pkg::addr_t   i_f_paddr,
  output logic                    o_f_pready,
  output saturn_bus_pkg::nibble_t o_f_prdata,
  // data channel
  input  logic                    i_d_psel,
  input  logic                    i_d_penable,
  input  logic                    i_d_pwrite,
  input  saturn_bus_pkg::addr_t   i_d_paddr,
  input  saturn_bus_pkg::nibble_t i_d_pwdata,
  output logic                    o_d_pready,
  output saturn_bus_pkg::nibble_t o_d_prdata
);
  import saturn_bus_pkg::*;

  logic      f_req;
  logic      f_req_load;
  addr_t     f_req_addr;
  logic      f_gnt;
  logic      d_req;
  logic      d_req_load;
  req_kind_e d_req_kind;
  addr_t     d_req_addr;
  nibble_t   d_req_wdata;
  logic      d_gnt;
  logic      fetch_flush;
  logic      req;
  logic      req_load;
  req_kind_e req_kind;
  addr_t     req_addr;
  nibble_t   req_wdata;
  logic      sel_data;
  logic      done;
  nibble_t   rdata;
  // nibble bus
  nibble_t   ctrl_bus_data;
  nibble_t   mem_bus_data;
  logic      bus_strobe;
  logic      bus_cmd_data;

  saturn_fetch_port saturn_fetch_port_inst (
    .i_clk         (i_clk),
    .do_cmd_reset  (do_cmd_reset),
    .i_psel        (i_f_psel),
    .i_penable     (i_f_penable),
    .i_paddr       (i_f_paddr),
    .i_gnt         (f_gnt),
    .i_done        (done),
    .i_rdata       (rdata),
    .i_fetch_flush (fetch_flush),
    .o_pready      (o_f_pready),
    .o_prdata      (o_f_prdata),
    .o_req         (f_req),
    .o_req_load    (f_req_load),
    .o_req_addr    (f_req_addr)
  );

  saturn_data_port saturn_data_port_inst (
    .i_clk        (i_clk),
    .do_cmd_reset (do_cmd_reset),
    .i_psel       (i_d_psel),
    .i_penable    (i_d_penable),
    .i_pwrite     (i_d_pwrite),
    .i_paddr      (i_d_paddr),
    .i_pwdata     (i_d_pwdata),
    .i_gnt        (d_gnt),
    .i_done       (done),
    .i_rdata      (rdata),
    .o_pready     (o_d_pready),
    .o_prdata     (o_d_prdata),
    .o_req        (d_req),
    .o_req_load   (d_req_load),
    .o_req_kind   (d_req_kind),
    .o_req_addr   (d_req_addr),
    .o_req_wdata  (d_req_wdata)
  );

  saturn_bus_arbiter saturn_bus_arbiter_inst (
    .i_clk            (i_clk),
    .do_cmd_reset     (do_cmd_reset),
    .i_fetch_req      (f_req),
    .i_fetch_req_load (f_req_load),
    .i_fetch_req_addr (f_req_addr),
    .i_data_req       (d_req),
    .i_data_req_load  (d_req_load),
    .i_data_req_kind  (d_req_kind),
    .i_data_req_addr  (d_req_addr),
    .i_data_req_wdata (d_req_wdata),
    .i_done           (done),
    .o_fetch_gnt      (f_gnt),
    .o_data_gnt       (d_gnt),
    .o_req            (req),
    .o_req_load       (req_load),
    .o_req_kind       (req_kind),
    .o_req_addr       (req_addr),
    .o_req_wdata      (req_wdata),
    .o_sel_data       (sel_data),
    .o_fetch_flush    (fetch_flush)
  );

  saturn_bus_ctrl saturn_bus_ctrl_inst (
    .i_clk          (i_clk),
    .do_cmd_reset   (do_cmd_reset),
    .i_req          (req),
    .i_req_load     (req_load),
    .i_req_kind     (req_kind),
    .i_req_addr     (req_addr),
    .i_req_wdata    (req_wdata),
    .i_sel_data     (sel_data),
    .i_bus_data     (mem_bus_data),
    .o_bus_data     (ctrl_bus_data),
    .o_bus_strobe   (bus_strobe),
    .o_bus_cmd_data (bus_cmd_data),
    .o_done         (done),
    .o_rdata        (rdata)
  );

  saturn_nibble_mem saturn_nibble_mem_inst (
    .i_clk          (i_clk),
    .do_cmd_reset   (do_cmd_reset),
    .i_bus_data     (ctrl_bus_data),
    .i_bus_strobe   (bus_strobe),
    .i_bus_cmd_data (bus_cmd_data),
    .o_bus_data     (mem_bus_data)
  );

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 4
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
  end

  // free running, first rising edge half a period in
  always begin
    #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

endmodule

/* dv/saturn_bus_tb.sv */
`timescale 1ns/100ps

module saturn_bus_tb;
  import saturn_bus_pkg::*;

  localparam STIM_FILE = "dv/saturn_bus_stim.txt";
  // cycles any single pready wait may take
  localparam int WAIT_LIMIT = 64;

  logic    clk;
  logic    do_cmd_reset;
  logic    f_psel;
  logic    f_penable;
  addr_t   f_paddr;
  logic    f_pready;
  nibble_t f_prdata;
  logic    d_psel;
  logic    d_penable;
  logic    d_pwrite;
  addr_t   d_paddr;
  nibble_t d_pwdata;
  logic    d_pready;
  nibble_t d_prdata;

  // stimulus table, one entry per data line of the file
  bit      is_data_q[$];
  bit      is_write_q[$];
  addr_t   addr_q[$];
  nibble_t wdata_q[$];
  nibble_t exp_q[$];
  bit      pair_q[$];

  int      err_count;
  int      fetch_count = 0;
  int      data_count = 0;
  int      fetch_total;
  int      data_total;
  addr_t   last_f_addr;
  addr_t   last_d_addr;

  tb_clock_gen #(.PERIOD_NS(4)) tb_clock_gen_inst (.o_clk(clk));

  saturn_bus_top saturn_bus_top_inst (
    .i_clk        (clk),
    .do_cmd_reset (do_cmd_reset),
    .i_f_psel     (f_psel),
    .i_f_penable  (f_penable),
    .i_f_paddr    (f_paddr),
    .o_f_pready   (f_pready),
    .o_f_prdata   (f_prdata),
    .i_d_psel     (d_psel),
    .i_d_penable  (d_penable),
    .i_d_pwrite   (d_pwrite),
    .i_d_paddr    (d_paddr),
    .i_d_pwdata   (d_pwdata),
    .o_d_pready   (d_pready),
    .o_d_prdata   (d_prdata)
  );

  // completed transfers per channel, sampled mid cycle
  always @(negedge clk) begin
    #1;
    if (!do_cmd_reset && f_pready) begin
      fetch_count++;
    end
    if (!do_cmd_reset && d_pready) begin
      data_count++;
    end
  end

  task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_nibble(input string what, input addr_t addr,
                              input nibble_t got, input nibble_t exp);
    if (got !== exp) begin
      err_count++;
      $display("CHECK FAILED at %0t: %s read at %05h returned %h, expected %h",
               $time, what, addr, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input string what, input addr_t last_addr,
                             input int got, input int exp);
    if (got != exp) begin
      err_count++;
      $display("CHECK FAILED at %0t: %s port completed %0d transfers, expected %0d (last %05h)",
               $time, what, got, exp, last_addr);
      abort_run();
    end
  endtask

  task automatic report_timeout(input string what, input addr_t addr);
    err_count++;
    $display("Timeout: %s access at %05h saw no pready within %0d cycles",
             what, addr, WAIT_LIMIT);
    abort_run();
  endtask

  task automatic fetch_read(input addr_t addr, input nibble_t exp);
    int      waits;
    nibble_t got;
    @(negedge clk);
    f_psel    = 1'b1;
    f_penable = 1'b0;
    f_paddr   = addr;
    @(negedge clk);
    f_penable = 1'b1;
    // sample mid cycle, once the hit logic has settled
    #1;
    waits = 0;
    while (!f_pready) begin
      if (waits == WAIT_LIMIT) begin
        report_timeout("fetch", addr);
      end
      @(negedge clk);
      #1;
      waits++;
    end
    got = f_prdata;
    @(negedge clk);
    f_psel    = 1'b0;
    f_penable = 1'b0;
    last_f_addr = addr;
    check_nibble("fetch", addr, got, exp);
  endtask

  task automatic data_access(input bit write, input addr_t addr,
                             input nibble_t wdata, input nibble_t exp);
    int      waits;
    nibble_t got;
    @(negedge clk);
    d_psel    = 1'b1;
    d_penable = 1'b0;
    d_pwrite  = write;
    d_paddr   = addr;
    d_pwdata  = wdata;
    @(negedge clk);
    d_penable = 1'b1;
    #1;
    waits = 0;
    while (!d_pready) begin
      if (waits == WAIT_LIMIT) begin
        report_timeout("data", addr);
      end
      @(negedge clk);
      #1;
      waits++;
    end
    got = d_prdata;
    @(negedge clk);
    d_psel    = 1'b0;
    d_penable = 1'b0;
    last_d_addr = addr;
    if (!write) begin
      check_nibble("data", addr, got, exp);
    end
  endtask

  task automatic run_entry(input int idx);
    if (is_data_q[idx]) begin
      data_access(is_write_q[idx], addr_q[idx], wdata_q[idx], exp_q[idx]);
    end else begin
      fetch_read(addr_q[idx], exp_q[idx]);
    end
  endtask

  task automatic load_stim();
    int            fd;
    int            code;
    int            pair;
    logic [63:0]   tok;
    logic [63:0]   dir_s;
    logic [1023:0] rest;
    addr_t         addr;
    nibble_t       wdata;
    nibble_t       exp;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      err_count++;
      $display("Could not open the stimulus file %s", STIM_FILE);
      abort_run();
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", tok);
        if ((code == 1) && (tok == "#")) begin
          // column description line
          code = $fgets(rest, fd);
        end else if (code == 1) begin
          code = $fscanf(fd, "%s %h %h %h %d", dir_s, addr, wdata, exp, pair);
          if ((code != 5) || !((tok == "F") || (tok == "D"))) begin
            err_count++;
            $display("Stimulus line %0d is malformed", addr_q.size() + 1);
            abort_run();
          end else begin
            is_data_q.push_back(tok == "D");
            is_write_q.push_back(dir_s == "W");
            addr_q.push_back(addr);
            wdata_q.push_back(wdata);
            exp_q.push_back(exp);
            pair_q.push_back(pair != 0);
            if (tok == "D") begin
              data_total++;
            end else begin
              fetch_total++;
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    int idx;
    err_count    = 0;
    fetch_total  = 0;
    data_total   = 0;
    last_f_addr  = '0;
    last_d_addr  = '0;
    do_cmd_reset = 1'b1;
    f_psel       = 1'b0;
    f_penable    = 1'b0;
    f_paddr      = '0;
    d_psel       = 1'b0;
    d_penable    = 1'b0;
    d_pwrite     = 1'b0;
    d_paddr      = '0;
    d_pwdata     = '0;
    load_stim();
    repeat (2) @(posedge clk);
    @(negedge clk);
    do_cmd_reset = 1'b0;
    idx = 0;
    while (idx < addr_q.size()) begin
      // paired lines start on both channels in the same cycle
      if (pair_q[idx] && (idx + 1 < addr_q.size())) begin
        fork
          run_entry(idx);
          run_entry(idx + 1);
        join
        idx += 2;
      end else begin
        run_entry(idx);
        idx += 1;
      end
    end
    check_count("fetch", last_f_addr, fetch_count, fetch_total);
    check_count("data", last_d_addr, data_count, data_total);
    if (err_count == 0) begin
      $display("Regression passed");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

/* dv/saturn_bus_stim.txt */
# port(F/D) dir(R/W) addr(hex) wdata(hex) expect(hex) pair(0/1)
# expect is checked on reads only, pair 1 starts this line in the same cycle as the next
D W 00010 5 0 0
D W 00011 a 0 0
D W 00012 3 0 0
D R 00010 0 5 0
D R 00011 0 a 0
D R 00012 0 3 0
D W 00013 c 0 0
D R 00013 0 c 0
F R 00010 0 5 0
F R 00011 0 a 0
F R 00012 0 3 0
F R 00013 0 c 0
D W 00120 7 0 0
D R 00020 0 7 0
F R 00120 0 7 0
D R 03f11 0 a 0
F R 00030 0 0 0
D W 00031 9 0 0
F R 00031 0 9 0
F R 00014 0 0 1
D W 00050 6 0 0
F R 00015 0 0 1
D R 00050 0 6 0
F R 00011 0 a 1
D W 00051 e 0 0
F R 00050 0 6 1
D R 00051 0 e 0

/* all.f */
hw/saturn_bus_pkg.sv
hw/saturn_fetch_port.sv
hw/saturn_data_port.sv
hw/saturn_bus_arbiter.sv
hw/saturn_bus_ctrl.sv
hw/saturn_nibble_mem.sv
hw/saturn_bus_top.sv
dv/tb_clock_gen.sv
dv/saturn_bus_tb.sv

/* Bender.yml */
package:
  name: saturn_bus

sources:
  - hw/saturn_bus_pkg.sv
  - hw/saturn_fetch_port.sv
  - hw/saturn_data_port.sv
  - hw/saturn_bus_arbiter.sv
  - hw/saturn_bus_ctrl.sv
  - hw/saturn_nibble_mem.sv
  - hw/saturn_bus_top.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/saturn_bus_tb.sv
